//--- list.f
design/cache_pkg.sv
design/cpu_req_stage.sv
design/cache_way.sv
design/cache_ctrl.sv
design/mem_port.sv
design/cache_top.sv
verification/mem_model.sv
verification/cache_tb.sv

//--- Makefile
# Verilator flow for the two-way data cache
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=
PASS_TEXT ?= SIMULATION PASSED

COMMON  = --timing --assert -f $(FILELIST) --top-module $(TOP)
SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON) $(VFLAGS)

build:
	$(VERILATOR) --binary $(COMMON) -Mdir $(BUILD_DIR) $(VFLAGS)

# the run counts as passed only if the pass line shows up in its output
sim: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam int IDX_W       = 4;       // 16 sets give frequent evictions
    localparam int SETS        = 1 << IDX_W;
    localparam int TAG_W       = 28 - IDX_W;
    localparam int CLK_PERIOD  = 20;
    localparam int N_RANDOM    = 300;
    localparam int FLUSH_LINES = 64;      // four new tags per set
    localparam int REQ_BUDGET  = 200;     // cycles allowed for one request
    localparam int MAX_REQS    = N_RANDOM + FLUSH_LINES + 1024;

    logic               clk = 1'b0;
    logic               resetn;
    logic               valid;
    cache_pkg::cpu_op_e op;
    logic [31:0]        addr;
    logic [3:0]         wstrb;
    logic [31:0]        wdata;
    logic               addr_ok;
    logic               data_ok;
    logic [31:0]        rdata;
    logic               rd_req;
    logic [31:0]        rd_addr;
    logic               rd_rdy;
    logic               ret_valid;
    logic               ret_last;
    logic [31:0]        ret_data;
    logic               wr_req;
    logic [31:0]        wr_addr;
    cache_pkg::line_t   wr_data;
    logic               wr_rdy;

    logic [31:0]      shadow [1024];      // expected memory image
    logic             touched [1024];
    logic [1:0]       m_valid [SETS];     // one bit per way
    logic [1:0]       m_dirty [SETS];
    logic [TAG_W-1:0] m_tag [SETS][2];
    logic             m_repl [SETS];
    logic [31:0]      wb_expect [$];      // victim lines still owed to memory
    string            test_name;

    cache_top #(.INDEX_W(IDX_W)) dut0 (.*);
    mem_model mem0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic stop_with_error(input string what);
        $display("error in %s: %s", test_name, what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] pattern_word(input logic [9:0] i);
        return (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
    endfunction

    // two-way set model that returns 1 on a hit
    function automatic logic track_sets(input logic [31:0] a, input logic store);
        logic [IDX_W-1:0] s;
        logic [TAG_W-1:0] t;
        logic             v;
        s = a[IDX_W+3:4];
        t = a[31:IDX_W+4];
        for (int w = 0; w < 2; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                m_repl[s] = (w == 0);       // hit points at the other way
                if (store) begin
                    m_dirty[s][w] = 1'b1;
                end
                return 1'b1;
            end
        end
        v = m_repl[s];
        if (m_valid[s][v] && m_dirty[s][v]) begin
            wb_expect.push_back({m_tag[s][v], s, 4'h0});
        end
        m_valid[s][v] = 1'b1;
        m_tag[s][v]   = t;
        m_dirty[s][v] = store;
        m_repl[s]     = ~v;                 // refill flips
        return 1'b0;
    endfunction

    task automatic issue_request(input cache_pkg::cpu_op_e o, input logic [31:0] a,
                                 input logic [3:0] be, input logic [31:0] d);
        logic        hit_pred;
        logic        rd_seen;
        logic [31:0] expected;
        logic [31:0] line_addr;
        int          cycles;
        valid <= 1'b1;
        op    <= o;
        addr  <= a;
        wstrb <= be;
        wdata <= d;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        valid <= 1'b0;                      // accepted at this edge
        touched[a[11:2]] = 1'b1;
        if (o == cache_pkg::OP_WRITE) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    shadow[a[11:2]][b*8 +: 8] = d[b*8 +: 8];
                end
            end
        end
        expected  = shadow[a[11:2]];
        line_addr = {a[31:4], 4'h0};
        hit_pred  = track_sets(a, o == cache_pkg::OP_WRITE);
        cycles    = 0;
        rd_seen   = 1'b0;
        do begin
            @(posedge clk);
            cycles++;
            rd_seen |= rd_req;
            if (rd_req) begin
                assert (rd_addr == line_addr)
                    else mismatch("refill address", line_addr, rd_addr);
            end
            if (cycles > REQ_BUDGET) begin
                stop_with_error("no data_ok within the per-request cycle budget");
            end
        end while (!data_ok);
        if (o == cache_pkg::OP_READ) begin
            assert (rdata == expected) else mismatch("read data", expected, rdata);
        end
        if (hit_pred) begin
            assert (cycles == 1) else mismatch("hit latency", 1, cycles);
            assert (!rd_seen) else stop_with_error("hit issued a refill read");
        end else begin
            assert (rd_seen) else stop_with_error("miss finished without a refill read");
        end
        assert (wb_expect.size() == 0) else stop_with_error("dirty victim was not written back");
    endtask

    // each line write must be a predicted dirty victim carrying the shadow line
    always @(posedge clk) begin
        if (resetn && wr_req && wr_rdy) begin
            assert (wb_expect.size() != 0)
                else stop_with_error("write-back of a line not stored to since its fill");
            assert (wr_addr == wb_expect[0]) else mismatch("wb address", wb_expect[0], wr_addr);
            for (int w = 0; w < 4; w++) begin
                assert (wr_data[w] == shadow[{wr_addr[11:4], w[1:0]}])
                    else mismatch("wb data", shadow[{wr_addr[11:4], w[1:0]}], wr_data[w]);
            end
            void'(wb_expect.pop_front());
        end
    end

    initial begin
        #((MAX_REQS * REQ_BUDGET + 100) * CLK_PERIOD);
        stop_with_error("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [3:0]  be;
        r = 32'hd129;
        test_name = "reset";
        for (int i = 0; i < 1024; i++) begin
            shadow[i]  = pattern_word(10'(i));
            touched[i] = 1'b0;
        end
        for (int s = 0; s < SETS; s++) begin
            m_valid[s] = 2'b00;
            m_dirty[s] = 2'b00;
            m_repl[s]  = 1'b0;
        end
        resetn <= 1'b0;
        valid  <= 1'b0;
        op     <= cache_pkg::OP_READ;
        addr   <= 32'h0;
        wstrb  <= 4'h0;
        wdata  <= 32'h0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        assert (addr_ok && !data_ok && !rd_req && !wr_req)
            else stop_with_error("after reset addr_ok must be high, data_ok/rd_req/wr_req low");

        test_name = "random";               // 1 KiB window with 4 tags per set
        for (int n = 0; n < N_RANDOM; n++) begin
            r = xorshift(r);
            a = {22'd0, r[9:2], 2'b00};
            if (r[16]) begin
                be = (r[23:20] == 4'h0) ? 4'hf : r[23:20];
                r  = xorshift(r);
                issue_request(cache_pkg::OP_WRITE, a, be, r);
            end else begin
                issue_request(cache_pkg::OP_READ, a, 4'h0, 32'h0);
            end
        end

        test_name = "flush";                // pushes every dirty line out
        for (int l = 0; l < FLUSH_LINES; l++) begin
            issue_request(cache_pkg::OP_READ, {20'd0, 2'b10, 6'(l), 4'h0}, 4'h0, 32'h0);
        end

        test_name = "sweep";
        for (int i = 0; i < 1024; i++) begin
            if (touched[i]) begin
                issue_request(cache_pkg::OP_READ, {20'd0, 10'(i), 2'b00}, 4'h0, 32'h0);
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic             clk,
    input  logic             resetn,
    input  logic             rd_req,
    input  logic [31:0]      rd_addr,
    output logic             rd_rdy,
    output logic             ret_valid,
    output logic             ret_last,
    output logic [31:0]      ret_data,
    input  logic             wr_req,
    input  logic [31:0]      wr_addr,
    input  cache_pkg::line_t wr_data,
    output logic             wr_rdy
);

    logic [31:0] words [1024];          // 4 KiB, word address is addr[11:2]
    logic [31:0] rnd         = 32'hd129;
    logic        rd_rdy_q    = 1'b0;
    logic        wr_rdy_q    = 1'b0;
    logic        ret_valid_q = 1'b0;
    logic        ret_last_q  = 1'b0;
    logic [31:0] ret_data_q  = 32'h0;
    logic        busy        = 1'b0;    // refill beats still owed
    logic [7:0]  line_q      = 8'h0;
    logic [1:0]  beat_q      = 2'd0;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] pattern_word(input logic [9:0] i);
        return (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            words[i] = pattern_word(10'(i));
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy_q    <= 1'b0;
            wr_rdy_q    <= 1'b0;
            ret_valid_q <= 1'b0;
            ret_last_q  <= 1'b0;
            busy        <= 1'b0;
            beat_q      <= 2'd0;
        end else begin
            rnd         <= xorshift(rnd);
            rd_rdy_q    <= rnd[0] | rnd[1];   // stalls about one cycle in four
            wr_rdy_q    <= rnd[2] | rnd[3];
            ret_valid_q <= 1'b0;
            ret_last_q  <= 1'b0;
            if (busy) begin
                if (rnd[4] | rnd[5]) begin    // random gaps between beats
                    ret_valid_q <= 1'b1;
                    ret_data_q  <= words[{line_q, beat_q}];
                    ret_last_q  <= (beat_q == 2'd3);
                    beat_q      <= beat_q + 2'd1;
                    busy        <= (beat_q != 2'd3);
                end
            end else if (rd_req && rd_rdy_q) begin
                busy   <= 1'b1;
                line_q <= rd_addr[11:4];
                beat_q <= 2'd0;
            end
            if (wr_req && wr_rdy_q) begin
                for (int w = 0; w < 4; w++) begin
                    words[{wr_addr[11:4], w[1:0]}] <= wr_data[w];
                end
            end
        end
    end

    assign rd_rdy    = rd_rdy_q;
    assign wr_rdy    = wr_rdy_q;
    assign ret_valid = ret_valid_q;
    assign ret_last  = ret_last_q;
    assign ret_data  = ret_data_q;

endmodule

`default_nettype wire

//--- design/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int INDEX_W = 8
) (
    input  logic                clk,
    input  logic                resetn,
    // cpu side
    input  logic                valid,
    input  cache_pkg::cpu_op_e  op,
    input  logic [31:0]         addr,
    input  logic [3:0]          wstrb,
    input  logic [31:0]         wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output logic [31:0]         rdata,
    // memory side
    output logic                rd_req,
    output logic [31:0]         rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [31:0]         ret_data,
    output logic                wr_req,
    output logic [31:0]         wr_addr,
    output cache_pkg::line_t    wr_data,
    input  logic                wr_rdy
);

    logic                accept;
    logic                idle;
    cache_pkg::cpu_req_t req;
    logic [INDEX_W-1:0]  rd_index;

    cache_pkg::way_wr_t  way0_wr;
    cache_pkg::way_wr_t  way1_wr;
    cache_pkg::way_rd_t  way0_rd;
    cache_pkg::way_rd_t  way1_rd;

    logic                fill_start;
    logic [31:0]         fill_addr;
    logic                fill_done;
    cache_pkg::line_t    fill_line;
    logic                wb_start;
    logic [31:0]         wb_addr;
    cache_pkg::line_t    wb_line;
    logic                wb_done;

    cpu_req_stage #(.INDEX_W(INDEX_W)) u_req_stage (
        .clk      (clk),
        .resetn   (resetn),
        .valid    (valid),
        .op       (op),
        .addr     (addr),
        .wstrb    (wstrb),
        .wdata    (wdata),
        .idle     (idle),
        .addr_ok  (addr_ok),
        .accept   (accept),
        .req      (req),
        .rd_index (rd_index)
    );

    cache_way #(.INDEX_W(INDEX_W)) u_way0 (
        .clk      (clk),
        .resetn   (resetn),
        .rd_index (rd_index),
        .wr       (way0_wr),
        .rd       (way0_rd)
    );

    cache_way #(.INDEX_W(INDEX_W)) u_way1 (
        .clk      (clk),
        .resetn   (resetn),
        .rd_index (rd_index),
        .wr       (way1_wr),
        .rd       (way1_rd)
    );

    cache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .accept     (accept),
        .req        (req),
        .way0_rd    (way0_rd),
        .way1_rd    (way1_rd),
        .way0_wr    (way0_wr),
        .way1_wr    (way1_wr),
        .idle       (idle),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .fill_done  (fill_done),
        .fill_line  (fill_line),
        .wb_start   (wb_start),
        .wb_addr    (wb_addr),
        .wb_line    (wb_line),
        .wb_done    (wb_done)
    );

    mem_port #(.INDEX_W(INDEX_W)) u_mem_port (
        .clk        (clk),
        .resetn     (resetn),
        .fill_start (fill_start),
        .fill_addr  (fill_addr),
        .fill_done  (fill_done),
        .fill_line  (fill_line),
        .wb_start   (wb_start),
        .wb_addr    (wb_addr),
        .wb_line    (wb_line),
        .wb_done    (wb_done),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_rdy     (wr_rdy)
    );

endmodule

`default_nettype wire

//--- design/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port #(
    parameter int INDEX_W = 8
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             fill_start,
    input  logic [31:0]      fill_addr,
    output logic             fill_done,
    output cache_pkg::line_t fill_line,
    input  logic             wb_start,
    input  logic [31:0]      wb_addr,
    input  cache_pkg::line_t wb_line,
    output logic             wb_done,
    output logic             rd_req,
    output logic [31:0]      rd_addr,
    input  logic             rd_rdy,
    input  logic             ret_valid,
    input  logic             ret_last,
    input  logic [31:0]      ret_data,
    output logic             wr_req,
    output logic [31:0]      wr_addr,
    output cache_pkg::line_t wr_data,
    input  logic             wr_rdy
);

    localparam int TAG_W = 28 - INDEX_W;

    logic [TAG_W-1:0]   rd_tag_q;
    logic [INDEX_W-1:0] rd_idx_q;
    logic [TAG_W-1:0]   wr_tag_q;
    logic [INDEX_W-1:0] wr_idx_q;
    logic [1:0]         beat_q;       // next word of the refill line

    // requests stay up until the bus takes them
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_req    <= 1'b0;
            wr_req    <= 1'b0;
            beat_q    <= '0;
            fill_done <= 1'b0;
        end else begin
            if (fill_start) begin
                rd_req <= 1'b1;
            end else if (rd_rdy) begin
                rd_req <= 1'b0;
            end
            if (wb_start) begin
                wr_req <= 1'b1;
            end else if (wr_rdy) begin
                wr_req <= 1'b0;
            end
            if (ret_valid) begin
                beat_q <= ret_last ? 2'd0 : beat_q + 2'd1;
            end
            fill_done <= ret_valid & ret_last;   // line complete next cycle
        end
    end

    // addresses and write line, steady while waiting for rdy
    always_ff @(posedge clk) begin
        if (fill_start) begin
            rd_tag_q <= fill_addr[31:INDEX_W+4];
            rd_idx_q <= fill_addr[INDEX_W+3:4];
        end
        if (wb_start) begin
            wr_tag_q <= wb_addr[31:INDEX_W+4];
            wr_idx_q <= wb_addr[INDEX_W+3:4];
            wr_data  <= wb_line;
        end
        if (ret_valid) begin
            fill_line[beat_q] <= ret_data;
        end
    end

    assign rd_addr = {rd_tag_q, rd_idx_q, 4'b0000};
    assign wr_addr = {wr_tag_q, wr_idx_q, 4'b0000};
    assign wb_done = wr_req & wr_rdy;

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int INDEX_W = 8
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                accept,
    input  cache_pkg::cpu_req_t req,
    input  cache_pkg::way_rd_t  way0_rd,
    input  cache_pkg::way_rd_t  way1_rd,
    output cache_pkg::way_wr_t  way0_wr,
    output cache_pkg::way_wr_t  way1_wr,
    output logic                idle,
    output logic                data_ok,
    output logic [31:0]         rdata,
    output logic                fill_start,
    output logic [31:0]         fill_addr,
    input  logic                fill_done,
    input  cache_pkg::line_t    fill_line,
    output logic                wb_start,
    output logic [31:0]         wb_addr,
    output cache_pkg::line_t    wb_line,
    input  logic                wb_done
);

    localparam int TAG_W = 28 - INDEX_W;
    localparam int SETS  = 1 << INDEX_W;

    cache_pkg::ctrl_state_e state_q;
    cache_pkg::ctrl_state_e state_d;

    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic [1:0]         word;
    logic               is_store;
    logic               hit0;
    logic               hit1;
    logic               hit;
    logic               victim;
    logic               need_wb;
    logic [SETS-1:0]    repl_q;       // way to evict next, per set
    cache_pkg::way_rd_t victim_rd;
    cache_pkg::line_t   refill_line;
    cache_pkg::way_wr_t wr_cmd;
    logic               wr_way;

    function automatic logic [31:0] merge_word(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign idx      = req.addr[INDEX_W+3:4];
    assign tag      = req.addr[31:INDEX_W+4];
    assign word     = req.addr[3:2];
    assign is_store = (req.op == cache_pkg::OP_WRITE);

    // tag compare against the lookup read
    assign hit0 = way0_rd.valid && (way0_rd.tag[TAG_W-1:0] == tag);
    assign hit1 = way1_rd.valid && (way1_rd.tag[TAG_W-1:0] == tag);
    assign hit  = hit0 | hit1;

    assign victim    = repl_q[idx];
    assign victim_rd = victim ? way1_rd : way0_rd;
    assign need_wb   = victim_rd.valid & victim_rd.dirty;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= cache_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            cache_pkg::ST_IDLE: begin
                if (accept) begin
                    state_d = cache_pkg::ST_LOOKUP;
                end
            end
            cache_pkg::ST_LOOKUP: begin
                if (hit) begin
                    state_d = cache_pkg::ST_IDLE;
                end else if (need_wb) begin
                    state_d = cache_pkg::ST_MISS;
                end else begin
                    state_d = cache_pkg::ST_REPLACE;
                end
            end
            cache_pkg::ST_MISS: begin
                if (wb_done) begin
                    state_d = cache_pkg::ST_REPLACE;
                end
            end
            cache_pkg::ST_REPLACE: state_d = cache_pkg::ST_REFILL;  // port is free here
            cache_pkg::ST_REFILL: begin
                if (fill_done) begin
                    state_d = cache_pkg::ST_IDLE;
                end
            end
            default: state_d = cache_pkg::ST_IDLE;
        endcase
    end

    // hit points at the other way, refill flips
    always_ff @(posedge clk) begin
        if (!resetn) begin
            repl_q <= '0;
        end else if (state_q == cache_pkg::ST_LOOKUP && hit) begin
            repl_q[idx] <= hit0;
        end else if (state_q == cache_pkg::ST_REFILL && fill_done) begin
            repl_q[idx] <= ~repl_q[idx];
        end
    end

    // returned line with the pending store folded in
    always_comb begin
        refill_line = fill_line;
        if (is_store) begin
            refill_line[word] = merge_word(fill_line[word], req.wdata, req.wstrb);
        end
    end

    always_comb begin
        wr_cmd       = '0;
        wr_way       = 1'b0;
        wr_cmd.index = cache_pkg::idx_t'(idx);
        wr_cmd.tag   = cache_pkg::tag_t'(tag);
        if (state_q == cache_pkg::ST_LOOKUP && hit && is_store) begin
            wr_cmd.data_we   = 1'b1;
            wr_cmd.dirty_we  = 1'b1;
            wr_cmd.dirty     = 1'b1;
            wr_cmd.ben[word] = req.wstrb;
            wr_cmd.data      = {cache_pkg::LINE_WORDS{req.wdata}};
            wr_way           = hit1;
        end else if (state_q == cache_pkg::ST_REFILL && fill_done) begin
            wr_cmd.tag_we   = 1'b1;
            wr_cmd.data_we  = 1'b1;
            wr_cmd.dirty_we = 1'b1;
            wr_cmd.dirty    = is_store;    // clean unless a store is merged
            wr_cmd.ben      = '1;
            wr_cmd.data     = refill_line;
            wr_way          = victim;
        end
    end

    // same command to both, enables only on the chosen way
    always_comb begin
        way0_wr = wr_cmd;
        way1_wr = wr_cmd;
        if (wr_way) begin
            way0_wr.tag_we   = 1'b0;
            way0_wr.data_we  = 1'b0;
            way0_wr.dirty_we = 1'b0;
        end else begin
            way1_wr.tag_we   = 1'b0;
            way1_wr.data_we  = 1'b0;
            way1_wr.dirty_we = 1'b0;
        end
    end

    assign idle    = (state_q == cache_pkg::ST_IDLE);
    assign data_ok = (state_q == cache_pkg::ST_LOOKUP && hit) ||
                     (state_q == cache_pkg::ST_REFILL && fill_done);

    always_comb begin
        if (state_q == cache_pkg::ST_REFILL) begin
            rdata = refill_line[word];
        end else if (hit1) begin
            rdata = way1_rd.line[word];
        end else begin
            rdata = way0_rd.line[word];
        end
    end

    // memory side requests
    assign fill_start = (state_q == cache_pkg::ST_REPLACE);
    assign fill_addr  = {req.addr[31:4], 4'b0000};
    assign wb_start   = (state_q == cache_pkg::ST_LOOKUP) && !hit && need_wb;
    assign wb_addr    = {victim_rd.tag[TAG_W-1:0], idx, 4'b0000};
    assign wb_line    = victim_rd.line;

endmodule

`default_nettype wire

//--- design/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
    parameter int INDEX_W = 8
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic [INDEX_W-1:0] rd_index,
    input  cache_pkg::way_wr_t wr,
    output cache_pkg::way_rd_t rd
);

    localparam int TAG_W = 28 - INDEX_W;
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem [SETS];
    logic [31:0]      bank_mem [cache_pkg::LINE_WORDS][SETS];   // one bank per word
    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;
    logic [INDEX_W-1:0] widx;

    assign widx = wr.index[INDEX_W-1:0];

    // valid and dirty bits, cleared on reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (wr.tag_we) begin
                valid_q[widx] <= 1'b1;
            end
            if (wr.dirty_we) begin
                dirty_q[widx] <= wr.dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.tag_we) begin
            tag_mem[widx] <= wr.tag[TAG_W-1:0];
        end
        if (wr.data_we) begin
            for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr.ben[w][b]) begin
                        bank_mem[w][widx][b*8 +: 8] <= wr.data[w][b*8 +: 8];
                    end
                end
            end
        end
    end

    // synchronous read, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rd.valid <= valid_q[rd_index];
        rd.tag   <= cache_pkg::tag_t'(tag_mem[rd_index]);
        rd.dirty <= dirty_q[rd_index];
        for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
            rd.line[w] <= bank_mem[w][rd_index];
        end
    end

endmodule

`default_nettype wire

//--- design/cpu_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_req_stage #(
    parameter int INDEX_W = 8
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  cache_pkg::cpu_op_e  op,
    input  logic [31:0]         addr,
    input  logic [3:0]          wstrb,
    input  logic [31:0]         wdata,
    input  logic                idle,
    output logic                addr_ok,
    output logic                accept,
    output cache_pkg::cpu_req_t req,
    output logic [INDEX_W-1:0]  rd_index
);

    cache_pkg::cpu_req_t req_q;

    // one request in flight, so the address is taken only when idle
    assign addr_ok = idle;
    assign accept  = valid & idle;

    // request buffer
    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_q <= '0;
        end else if (accept) begin
            req_q.op    <= op;
            req_q.addr  <= addr;
            req_q.wstrb <= wstrb;
            req_q.wdata <= wdata;
        end
    end

    assign req = req_q;

    // incoming index while idle so the ways have data in lookup,
    // held index afterwards for writeback and refill
    always_comb begin
        if (idle) begin
            rd_index = addr[INDEX_W+3:4];
        end else begin
            rd_index = req_q.addr[INDEX_W+3:4];
        end
    end

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int LINE_WORDS = 4;    // 16-byte lines
    localparam int IDX_MAX_W  = 8;    // widest index a way command can carry
    localparam int TAG_MAX_W  = 24;   // 28 - smallest supported INDEX_W (4)

    typedef logic [IDX_MAX_W-1:0] idx_t;
    typedef logic [TAG_MAX_W-1:0] tag_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cpu_op_e;

    typedef struct packed {
        cpu_op_e     op;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,     // dirty victim going out
        ST_REPLACE,
        ST_REFILL
    } ctrl_state_e;

    // write command into one way, tag_we also sets valid
    typedef struct packed {
        logic                       tag_we;
        logic                       data_we;
        logic                       dirty_we;
        idx_t                       index;
        tag_t                       tag;
        logic                       dirty;
        logic [LINE_WORDS-1:0][3:0] ben;     // byte enables per word
        line_t                      data;
    } way_wr_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        logic  dirty;
        line_t line;
    } way_rd_t;

endpackage

`default_nettype wire
